//--- logic/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo (
    input  logic clk_i,
    input  logic rst_n_i,
    input  synth_audio_pkg::voice_frame_t in_i,
    input  logic in_valid_i,
    output logic in_ready_o,
    output synth_audio_pkg::voice_frame_t out_o,
    output logic out_valid_o,
    input  logic out_ready_i
);
    import synth_audio_pkg::*;

    voice_frame_t mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr, rd_ptr; // the depth is a power of two, so they wrap freely.
    logic [FIFO_PTR_W:0] count; // one extra bit to tell full from empty.
    logic push, pop;

    assign in_ready_o = (count != (FIFO_PTR_W+1)'(FIFO_DEPTH));
    assign out_valid_o = (count != '0);
    assign push = in_valid_i && in_ready_o;
    assign pop = out_valid_o && out_ready_i;
    assign out_o = mem[rd_ptr]; // head of the queue, readable the cycle after its write.

    always_ff @(posedge clk_i) begin
        if (push) mem[wr_ptr] <= in_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            // a push and a pop together leave the occupancy unchanged.
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/synth_audio_pkg.sv
`default_nettype none

package synth_audio_pkg;

    localparam int NUM_VOICES = 4; // voices summed by the mixer.
    localparam int FIFO_DEPTH = 8; // frames held between generator and mixer.
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef logic signed [15:0] sample_t; // one audio sample.
    typedef logic signed [15:0] gain_t; // Q1.15, so 0x7FFF is just below unity.

    // codes 2 and 3 are treated as square by the generator.
    typedef enum logic [1:0] {
        WAVE_SAW = 2'd0,
        WAVE_SQUARE = 2'd1
    } wave_sel_t;

    //////////////////////////////////////////////////
    // per voice settings and the frame format.
    //////////////////////////////////////////////////

    typedef struct packed {
        logic enable;
        wave_sel_t wave_sel;
        logic [31:0] increment; // added to the phase once per frame.
        gain_t gain;
    } voice_cfg_t;

    // one sample per voice, travelling with the gain it is mixed at.
    typedef struct packed {
        sample_t [NUM_VOICES-1:0] sample;
        gain_t [NUM_VOICES-1:0] gain;
    } voice_frame_t;

endpackage

`default_nettype wire

//--- logic/synth_bus_pkg.sv
`default_nettype none

package synth_bus_pkg;

    //////////////////////////////////////////////////
    // register map of the synthesiser.
    //////////////////////////////////////////////////

    localparam int REG_ADDR_W = 12; // the bus spans 4096 word addresses.
    localparam logic [REG_ADDR_W-1:0] VOICE_BASE_ADDR = 12'h800; // table region lies below.
    localparam int VOICE_BLOCK_SIZE = 8; // registers per voice block.
    localparam int VOICE_OFF_W = $clog2(VOICE_BLOCK_SIZE);

    localparam logic [REG_ADDR_W-1:0] DUTY_ADDR = 12'h820; // square wave duty threshold.
    localparam logic [REG_ADDR_W-1:0] RUN_ADDR = 12'h821; // bit 0 starts the sample stream.

    // offsets within one voice block.
    localparam logic [VOICE_OFF_W-1:0] VOICE_CTRL_REG = 3'd0;
    localparam logic [VOICE_OFF_W-1:0] VOICE_INC_REG = 3'd1;
    localparam logic [VOICE_OFF_W-1:0] VOICE_GAIN_REG = 3'd2;

    // a write request is sampled on the edge where write is high.
    typedef struct packed {
        logic write;
        logic [REG_ADDR_W-1:0] addr;
        logic [3:0][7:0] data; // byte n is guarded by strobe bit n.
        logic [3:0] strobe;
    } reg_write_t;

    typedef struct packed {
        logic read;
        logic [REG_ADDR_W-1:0] addr;
    } reg_read_t;

    // replaces the strobed bytes of a register word with new bytes.
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [3:0][7:0] new_bytes,
                                                input logic [3:0] strobe);
        logic [3:0][7:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) result[b] = new_bytes[b];
        end
        return result;
    endfunction

endpackage

`default_nettype wire

//--- logic/synth_unit.sv
`timescale 1ns/1ps
`default_nettype none

module synth_unit (
    input  logic clk_i,
    input  logic rst_n_i,
    input  synth_bus_pkg::reg_write_t reg_write_i,
    input  synth_bus_pkg::reg_read_t reg_read_i,
    output logic [31:0] read_data_o,
    output synth_audio_pkg::sample_t sample_o,
    output logic sample_valid_o,
    input  logic sample_ready_i
);
    import synth_audio_pkg::*;

    voice_cfg_t voice_cfg [NUM_VOICES];
    logic [NUM_VOICES-1:0] voice_start;
    logic [31:0] duty;
    logic run;
    voice_frame_t gen_frame, mix_frame; // before and after the FIFO.
    logic gen_valid, gen_ready, mix_valid, mix_ready;

    unit_registers u_regs (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .reg_write_i   ( reg_write_i ),
        .reg_read_i    ( reg_read_i  ),
        .read_data_o   ( read_data_o ),
        .voice_cfg_o   ( voice_cfg   ),
        .voice_start_o ( voice_start ),
        .duty_o        ( duty        ),
        .run_o         ( run         )
    );

    voice_generator u_gen (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .voice_cfg_i (voice_cfg), .voice_start_i (voice_start),
        .duty_i (duty), .run_i (run),
        .frame_o (gen_frame), .frame_valid_o (gen_valid), .frame_ready_i (gen_ready)
    );

    sample_fifo u_fifo (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .in_i (gen_frame), .in_valid_i (gen_valid), .in_ready_o (gen_ready),
        .out_o (mix_frame), .out_valid_o (mix_valid), .out_ready_i (mix_ready)
    );

    voice_mixer u_mix (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .frame_i (mix_frame), .frame_valid_i (mix_valid), .frame_ready_o (mix_ready),
        .sample_o (sample_o), .sample_valid_o (sample_valid_o),
        .sample_ready_i (sample_ready_i)
    );

endmodule

`default_nettype wire

//--- logic/unit_registers.sv
`timescale 1ns/1ps
`default_nettype none

module unit_registers (
    input  logic clk_i,
    input  logic rst_n_i,
    input  synth_bus_pkg::reg_write_t reg_write_i,
    input  synth_bus_pkg::reg_read_t reg_read_i,
    output logic [31:0] read_data_o,
    output synth_audio_pkg::voice_cfg_t voice_cfg_o [synth_audio_pkg::NUM_VOICES],
    output logic [synth_audio_pkg::NUM_VOICES-1:0] voice_start_o,
    output logic [31:0] duty_o,
    output logic run_o
);
    import synth_bus_pkg::*;
    import synth_audio_pkg::*;

    logic [REG_ADDR_W-1:0] wr_rel, rd_rel; // addresses relative to the first voice block.
    logic [NUM_VOICES-1:0] wr_hit, rd_hit;
    logic [31:0] blk_data [NUM_VOICES];
    logic [31:0] duty_q;
    logic run_q;
    logic [31:0] run_word;

    //////////////////////////////////////////////////
    // voice blocks.
    //////////////////////////////////////////////////

    // addresses below the base wrap to a large block index and match no voice.
    assign wr_rel = reg_write_i.addr - VOICE_BASE_ADDR;
    assign rd_rel = reg_read_i.addr - VOICE_BASE_ADDR;

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        assign wr_hit[v] = reg_write_i.write &&
            (wr_rel[REG_ADDR_W-1:VOICE_OFF_W] == (REG_ADDR_W-VOICE_OFF_W)'(v));
        assign rd_hit[v] =
            (rd_rel[REG_ADDR_W-1:VOICE_OFF_W] == (REG_ADDR_W-VOICE_OFF_W)'(v));

        voice_registers u_voice (
            .clk_i          ( clk_i                            ),
            .rst_n_i        ( rst_n_i                          ),
            .write_i        ( wr_hit[v]                        ),
            .write_offset_i ( reg_write_i.addr[VOICE_OFF_W-1:0] ),
            .write_data_i   ( reg_write_i.data                 ),
            .write_strobe_i ( reg_write_i.strobe               ),
            .read_offset_i  ( reg_read_i.addr[VOICE_OFF_W-1:0]  ),
            .read_data_o    ( blk_data[v]                      ),
            .cfg_o          ( voice_cfg_o[v]                   ),
            .start_o        ( voice_start_o[v]                 )
        );
    end

    //////////////////////////////////////////////////
    // duty and run registers.
    //////////////////////////////////////////////////

    assign run_word = merge_bytes({31'b0, run_q}, reg_write_i.data, reg_write_i.strobe);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            duty_q <= '0;
            run_q <= 1'b0;
        end else if (reg_write_i.write) begin
            if (reg_write_i.addr == DUTY_ADDR) begin
                duty_q <= merge_bytes(duty_q, reg_write_i.data, reg_write_i.strobe);
            end
            if (reg_write_i.addr == RUN_ADDR) run_q <= run_word[0]; // only bit 0 is kept.
        end
    end

    assign duty_o = duty_q;
    assign run_o = run_q;

    // at most one source matches, so the words can simply be ORed.
    always_comb begin
        read_data_o = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (rd_hit[v]) read_data_o = read_data_o | blk_data[v];
        end
        if (reg_read_i.addr == DUTY_ADDR) read_data_o = read_data_o | duty_q;
        if (reg_read_i.addr == RUN_ADDR) read_data_o = read_data_o | {31'b0, run_q};
        if (!reg_read_i.read) read_data_o = '0; // idle bus reads zero.
    end

endmodule

`default_nettype wire

//--- logic/voice_generator.sv
`timescale 1ns/1ps
`default_nettype none

module voice_generator (
    input  logic clk_i,
    input  logic rst_n_i,
    input  synth_audio_pkg::voice_cfg_t voice_cfg_i [synth_audio_pkg::NUM_VOICES],
    input  logic [synth_audio_pkg::NUM_VOICES-1:0] voice_start_i,
    input  logic [31:0] duty_i,
    input  logic run_i,
    output synth_audio_pkg::voice_frame_t frame_o,
    output logic frame_valid_o,
    input  logic frame_ready_i
);
    import synth_audio_pkg::*;

    logic [31:0] phase_q [NUM_VOICES];
    voice_frame_t frame_d, frame_q;
    logic valid_q;
    logic load; // a new frame is formed at this edge.

    // the slot is free when empty or when the held frame transfers now.
    assign load = run_i && (!valid_q || frame_ready_i);

    //////////////////////////////////////////////////
    // waveform shaping.
    //////////////////////////////////////////////////

    always_comb begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            frame_d.gain[v] = voice_cfg_i[v].gain;
            if (!voice_cfg_i[v].enable) begin
                frame_d.sample[v] = '0; // a disabled voice is silent.
            end else if (voice_cfg_i[v].wave_sel == WAVE_SAW) begin
                frame_d.sample[v] = sample_t'(phase_q[v][31:16]); // ramp wraps to negative.
            end else if (phase_q[v] < duty_i) begin
                frame_d.sample[v] = 16'sh7FFF;
            end else begin
                frame_d.sample[v] = -16'sh7FFF; // symmetric around zero.
            end
        end
    end

    //////////////////////////////////////////////////
    // phase accumulators and frame register.
    //////////////////////////////////////////////////

    // phases advance once per formed frame. A formed frame is held until it
    // transfers, so a stall freezes the phases and nothing is skipped.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int v = 0; v < NUM_VOICES; v++) phase_q[v] <= '0;
            valid_q <= 1'b0;
        end else begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (voice_start_i[v]) begin
                    phase_q[v] <= '0; // the next frame of this voice starts at phase 0.
                end else if (load && voice_cfg_i[v].enable) begin
                    phase_q[v] <= phase_q[v] + voice_cfg_i[v].increment;
                end
            end
            if (load) valid_q <= 1'b1;
            else if (frame_ready_i) valid_q <= 1'b0; // run dropped and the last frame left.
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) frame_q <= frame_d;
    end

    assign frame_o = frame_q;
    assign frame_valid_o = valid_q;

endmodule

`default_nettype wire

//--- logic/voice_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module voice_mixer (
    input  logic clk_i,
    input  logic rst_n_i,
    input  synth_audio_pkg::voice_frame_t frame_i,
    input  logic frame_valid_i,
    output logic frame_ready_o,
    output synth_audio_pkg::sample_t sample_o,
    output logic sample_valid_o,
    input  logic sample_ready_i
);
    import synth_audio_pkg::*;

    logic signed [31:0] prod; // full 16 x 16 product.
    logic signed [19:0] sum; // four 17-bit terms need two bits of headroom.
    sample_t sat;
    sample_t sample_q;
    logic valid_q;

    //////////////////////////////////////////////////
    // gain, sum and saturation.
    //////////////////////////////////////////////////

    always_comb begin
        sum = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            prod = $signed(frame_i.sample[v]) * $signed(frame_i.gain[v]);
            sum = sum + 20'(prod >>> 15); // back to sample scale, rounding toward minus infinity.
        end
        if (sum > 20'sd32767) sat = 16'sh7FFF;
        else if (sum < -20'sd32768) sat = 16'sh8000;
        else sat = sum[15:0];
    end

    // the output register takes a frame when empty or being drained.
    assign frame_ready_o = !valid_q || sample_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (frame_valid_i && frame_ready_o) begin
            valid_q <= 1'b1;
        end else if (sample_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (frame_valid_i && frame_ready_o) sample_q <= sat; // held while the sink stalls.
    end

    assign sample_o = sample_q;
    assign sample_valid_o = valid_q;

endmodule

`default_nettype wire

//--- logic/voice_registers.sv
`timescale 1ns/1ps
`default_nettype none

module voice_registers (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic write_i,
    input  logic [2:0] write_offset_i,
    input  logic [3:0][7:0] write_data_i,
    input  logic [3:0] write_strobe_i,
    input  logic [2:0] read_offset_i,
    output logic [31:0] read_data_o,
    output synth_audio_pkg::voice_cfg_t cfg_o,
    output logic start_o
);
    import synth_bus_pkg::*;
    import synth_audio_pkg::*;

    logic enable_q; // control bit 0.
    logic [1:0] wave_sel_q; // control bits 3:2.
    logic [31:0] inc_q;
    gain_t gain_q;
    logic start_q;
    logic [31:0] ctrl_word, gain_word;
    logic [31:0] old_word, new_word;

    // the start bit is never stored, so it reads back as zero.
    assign ctrl_word = {28'b0, wave_sel_q, 1'b0, enable_q};
    assign gain_word = {16'b0, gain_q};

    always_comb begin
        case (write_offset_i) // current value of the register being written.
            VOICE_CTRL_REG: old_word = ctrl_word;
            VOICE_INC_REG:  old_word = inc_q;
            VOICE_GAIN_REG: old_word = gain_word;
            default:        old_word = '0;
        endcase
        case (read_offset_i) // unused offsets of the block read zero.
            VOICE_CTRL_REG: read_data_o = ctrl_word;
            VOICE_INC_REG:  read_data_o = inc_q;
            VOICE_GAIN_REG: read_data_o = gain_word;
            default:        read_data_o = '0;
        endcase
    end

    assign new_word = merge_bytes(old_word, write_data_i, write_strobe_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q <= 1'b0;
            wave_sel_q <= '0;
            inc_q <= '0;
            gain_q <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0; // the pulse lasts only the cycle after the write.
            if (write_i) begin
                case (write_offset_i)
                    VOICE_CTRL_REG: begin
                        enable_q <= new_word[0];
                        start_q <= new_word[1];
                        wave_sel_q <= new_word[3:2];
                    end
                    VOICE_INC_REG:  inc_q <= new_word;
                    VOICE_GAIN_REG: gain_q <= new_word[15:0];
                    default: ;
                endcase
            end
        end
    end

    assign cfg_o = '{enable: enable_q, wave_sel: wave_sel_t'(wave_sel_q),
                     increment: inc_q, gain: gain_q};
    assign start_o = start_q;

endmodule

`default_nettype wire

//--- project.f
logic/synth_bus_pkg.sv
logic/synth_audio_pkg.sv
logic/voice_registers.sv
logic/unit_registers.sv
logic/voice_generator.sv
logic/sample_fifo.sv
logic/voice_mixer.sv
logic/synth_unit.sv
tb/tb_synth_unit.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_synth_unit -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

out=$(./obj_dir/Vtb_synth_unit)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi
echo "$out" | grep -qx "All checks passed"
exit $?

//--- tb/synth_stim.txt
# W addr data strobe is a bus write and R addr value a read check, all fields in hex.
# S n s0 .. s(n-1) runs the stream for n samples, n in decimal and samples in hex.
# mapped registers read zero after reset.
R 800 00000000  R 801 00000000  R 80a 00000000  R 81a 00000000
R 820 00000000  R 821 00000000
# strobed writes to an increment, the duty word and a gain.
W 801 12345678 f  R 801 12345678  W 801 aabbccdd 5  R 801 12bb56dd
W 820 ffffffff 6  R 820 00ffff00  W 80a ffff8001 f  R 80a 00008001
# start reads back zero and the table region, unused offsets and gaps read zero.
W 818 0000000f 1  R 818 0000000d  W 7ff deadbeef f  R 7ff 00000000
R 803 00000000  R 80f 00000000  R 822 00000000  R fff 00000000
# voice 0 saw with increment 0x10000000 and gain 0x7fff.
W 801 10000000 f  W 802 00007fff 3  W 800 00000003 1
S 10 0000 0fff 1fff 2fff 3fff 4fff 5fff 6fff 8001 9000
# voice 1 square at half gain with duty 0x80000000.
W 800 00000000 1  W 809 40000000 f  W 80a 00004000 3  W 820 80000000 f  W 808 00000007 1
S 6 3fff 3fff c000 c000 3fff 3fff
# top duty byte alone moves to 0xc0 and a new start restarts the phase.
W 820 c0000000 8  R 820 c0000000  W 808 00000007 1
S 5 3fff 3fff 3fff c000 3fff
# three voices at full gain clip both ways while a loud voice 3 stays disabled.
W 80a 00007fff 3  W 811 20000000 f  W 812 00007fff 3  W 81a 00007fff 3  W 818 00000008 1
W 800 00000003 1  W 808 00000007 1  W 810 00000007 1
S 10 7fff 7fff 7fff 2ffe 7fff 7fff 5ffe 8000 7ffd 7fff
# run is clear again and voice 3 kept its wave select.
R 821 00000000  R 818 00000008

//--- tb/tb_synth_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_synth_unit;
    import synth_bus_pkg::*;
    import synth_audio_pkg::*;

    localparam int SEED = 84942;
    localparam string STIM_FILE = "tb/synth_stim.txt";

    logic clk_i;
    logic rst_n_i;
    reg_write_t reg_write;
    reg_read_t reg_read;
    logic [31:0] read_data;
    sample_t sample;
    logic sample_valid;
    logic sample_ready;

    //////////////////////////////////////////////////
    // stimulus parsed from the file, one entry per operation.
    //////////////////////////////////////////////////

    logic [7:0] op_kind [$]; // W, R or S.
    logic [31:0] op_addr [$], op_data [$], op_strobe [$]; // a run block keeps its count in op_addr.
    logic [15:0] exp_samples [$]; // expected mixer outputs of all run blocks, in order.
    int exp_pos = 0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycle_limit = 0; // zero until the file has been read.

    synth_unit synth_unit_inst (
        .clk_i          ( clk_i        ),
        .rst_n_i        ( rst_n_i      ),
        .reg_write_i    ( reg_write    ),
        .reg_read_i     ( reg_read     ),
        .read_data_o    ( read_data    ),
        .sample_o       ( sample       ),
        .sample_valid_o ( sample_valid ),
        .sample_ready_i ( sample_ready )
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i; // 40 ns period.
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic reg_write_t write_req(input logic [31:0] addr, data, strobe);
        reg_write_t req;
        req = '{write: 1'b1, addr: addr[REG_ADDR_W-1:0], data: data, strobe: strobe[3:0]};
        return req;
    endfunction

    // the write stays on the bus for one cycle, the next operation replaces it.
    task automatic bus_write(input logic [31:0] addr, data, strobe);
        @(posedge clk_i);
        #2;
        reg_read = '0;
        reg_write = write_req(addr, data, strobe);
    endtask

    task automatic read_check(input logic [31:0] addr, expected);
        @(posedge clk_i);
        #2;
        reg_write = '0;
        reg_read = '{read: 1'b1, addr: addr[REG_ADDR_W-1:0]};
        @(negedge clk_i); // read data is combinational and has settled mid-cycle.
        checks++;
        if (read_data !== expected) begin
            errors++;
            $display("Error: read_data_o at 0x%03h is 0x%08h, expected 0x%08h",
                     addr[REG_ADDR_W-1:0], read_data, expected);
        end
    endtask

    // sets run, clears it right after the last wanted frame forms, and checks every sample.
    task automatic run_block(input int count);
        int formed;
        int got;
        logic first;
        logic stopped;
        logic load_now;
        logic run_on;
        logic run_exp;
        formed = 0;
        got = 0;
        first = 1'b1;
        stopped = 1'b0;
        run_on = 1'b0;
        while (!stopped || got < count) begin
            @(posedge clk_i);
            #2;
            reg_read = '{read: 1'b1, addr: RUN_ADDR}; // the run bit is watched all along.
            run_exp = run_on; // writes from earlier cycles are visible now.
            load_now = synth_unit_inst.u_gen.load; // comes from registered state only.
            if (first) begin
                reg_write = write_req(RUN_ADDR, 32'h1, 32'h1);
                run_on = 1'b1;
            end else if (!stopped && formed + load_now >= count) begin
                reg_write = write_req(RUN_ADDR, 32'h0, 32'h1); // no frame forms after this edge.
                stopped = 1'b1;
                run_on = 1'b0;
            end else begin
                reg_write = '0;
            end
            formed += load_now;
            first = 1'b0;
            sample_ready = ($urandom % 3) != 0; // the sink stalls about a third of the time.
            @(negedge clk_i);
            checks++;
            if (read_data !== {31'b0, run_exp}) begin
                errors++;
                $display("Error: read_data_o at 0x%03h is 0x%08h, expected 0x%08h",
                         RUN_ADDR, read_data, {31'b0, run_exp});
            end
            if (sample_valid && sample_ready) begin
                checks++;
                if (got >= count) begin
                    errors++;
                    $display("More samples arrived than the %0d expected in this run.", count);
                end else if (sample !== exp_samples[exp_pos + got]) begin
                    errors++;
                    $display("Error: sample_o #%0d is 0x%04h, expected 0x%04h",
                             exp_pos + got, sample, exp_samples[exp_pos + got]);
                end
                got++;
            end
        end
        exp_pos += count;
        // with the sink open, a drained pipeline must stay silent.
        repeat (2 * FIFO_DEPTH) begin
            @(posedge clk_i);
            #2;
            reg_write = '0;
            sample_ready = 1'b1;
            @(negedge clk_i);
            if (sample_valid) begin
                errors++;
                $display("A sample showed up after all %0d samples of the run.", count);
            end
        end
        checks++;
    endtask

    initial begin
        int fd;
        int n;
        int rnd;
        int bus_ops;
        int total;
        logic [7:0] kind;
        logic [31:0] a, b, c, v;
        logic [8*128-1:0] rest;
        bus_ops = 0;
        total = 0;
        rnd = $urandom(SEED);
        rst_n_i = 1'b0;
        reg_write = '0;
        reg_read = '0;
        sample_ready = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("The stimulus file %s could not be opened.", STIM_FILE);
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                case (kind)
                    "#": n = $fgets(rest, fd); // a note runs to the end of its line.
                    "W", "R": begin
                        n = $fscanf(fd, "%h %h", a, b);
                        c = '0;
                        if (kind == "W") n = $fscanf(fd, "%h", c);
                        op_kind.push_back(kind);
                        op_addr.push_back(a);
                        op_data.push_back(b);
                        op_strobe.push_back(c);
                        bus_ops++;
                    end
                    "S": begin
                        n = $fscanf(fd, "%d", a);
                        repeat (a) begin
                            n = $fscanf(fd, "%h", v);
                            exp_samples.push_back(v[15:0]);
                        end
                        op_kind.push_back(kind);
                        op_addr.push_back(a);
                        op_data.push_back('0);
                        op_strobe.push_back('0);
                        total += a;
                    end
                    default: begin
                        errors++;
                        $display("The stimulus file holds an unknown entry '%c'.", kind);
                    end
                endcase
            end
            $fclose(fd);
        end
        cycle_limit = 200 * total + 50 * bus_ops;

        repeat (3) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;

        foreach (op_kind[i]) begin
            if (op_kind[i] == "W") bus_write(op_addr[i], op_data[i], op_strobe[i]);
            else if (op_kind[i] == "R") read_check(op_addr[i], op_data[i]);
            else run_block(op_addr[i]);
        end
        @(posedge clk_i);
        #2;
        reg_write = '0;
        reg_read = '0;

        $display("%0d checks done, %0d errors.", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
